//--- sim.f
verilog/gpio_pkg.sv
verilog/reg_bus_if.sv
verilog/ahb_slave_port.sv
verilog/gpio_regs.sv
verilog/pin_sync_edge.sv
verilog/gpio_top.sv
tb/tb_clock_gen.sv
tb/gpio_checker.sv
tb/tb_gpio.sv

//--- tb/gpio_checker.sv
`timescale 1ns/1ps
`default_nettype none

module gpio_checker
	import gpio_pkg::*;
(
	input  logic                hclk,
	input  logic                hresetn,
	input  logic [31:0]         haddr,
	input  logic                hsel,
	input  logic [DATA_W-1:0]   hwdata,
	input  logic                hwrite,
	input  logic [DATA_W-1:0]   hrdata,
	input  logic                hready,
	input  logic                hresp,
	input  logic                intc,
	input  logic [NUM_PINS-1:0] gpio_out,
	input  logic [NUM_PINS-1:0] gpio_in,
	output int                  err_cnt,
	output int                  chk_cnt
);

	// **********************************************************************
	// reference model state
	// **********************************************************************
	logic [DATA_W-1:0]    ctl_m [NUM_PINS]; // control words
	logic [DATA_W-1:0]    out_m [NUM_PINS]; // output words
	logic [NUM_PINS-1:0]  s1_m;             // first pad sample
	logic [NUM_PINS-1:0]  s2_m;             // second pad sample
	logic [NUM_PINS-1:0]  prev_m;           // level the input registers show
	logic                 wr_pend_m;        // write address phase waiting for data
	logic [REG_IDX_W-1:0] wr_idx_m;
	logic [DATA_W-1:0]    rdata_m;          // hrdata for the current cycle
	logic                 err1_m;           // first error cycle
	logic                 err2_m;           // second error cycle

	initial begin
		err_cnt = 0;
		chk_cnt = 0;
	end

	// word aligned and inside the twelve register map
	function automatic logic offs_decoded(input logic [OFFS_W-1:0] offs);
		return (offs[1:0] == 2'b00) && ((offs >> 2) < NUM_REGS);
	endfunction

	function automatic logic [DATA_W-1:0] model_read(input logic [REG_IDX_W-1:0] idx);
		int pin;
		int kind;
		pin  = idx / REGS_PER_PIN;
		kind = idx % REGS_PER_PIN;
		if (kind == KIND_CTL) return ctl_m[pin];
		if (kind == KIND_OUT) return out_m[pin];
		return DATA_W'(prev_m[pin]); // input word, level in bit 0
	endfunction

	// edge of the right polarity on an enabled pin
	function automatic logic expected_intc();
		logic hit;
		hit = 1'b0;
		for (int p = 0; p < NUM_PINS; p++) begin
			if (ctl_m[p][CTL_IRQ_EN_BIT]) begin
				if (ctl_m[p][CTL_RISE_BIT]) hit |= s2_m[p] & ~prev_m[p];
				else                        hit |= ~s2_m[p] & prev_m[p];
			end
		end
		return hit;
	endfunction

	task automatic check_value(input string name, input logic [DATA_W-1:0] exp,
			input logic [DATA_W-1:0] got);
		chk_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("ERR %0t %s exp=%0h got=%0h", $time, name, exp, got);
		end
	endtask

	task automatic reset_model();
		for (int p = 0; p < NUM_PINS; p++) begin
			ctl_m[p] = '0;
			out_m[p] = '0;
		end
		s1_m      = '0;
		s2_m      = '0;
		prev_m    = '0;
		wr_pend_m = 1'b0;
		wr_idx_m  = '0;
		rdata_m   = '0;
		err1_m    = 1'b0;
		err2_m    = 1'b0;
	endtask

	task automatic compare_outputs();
		check_value("hrdata", rdata_m, hrdata);
		check_value("hready", DATA_W'(!err1_m), DATA_W'(hready));
		check_value("hresp", DATA_W'(err1_m | err2_m), DATA_W'(hresp));
		check_value("intc", DATA_W'(expected_intc()), DATA_W'(intc));
		for (int p = 0; p < NUM_PINS; p++) begin
			check_value($sformatf("gpio_out[%0d]", p), DATA_W'(out_m[p][0]),
				DATA_W'(gpio_out[p]));
		end
	endtask

	// **********************************************************************
	// one rising edge of the model, from this cycle's inputs
	// **********************************************************************
	task automatic advance_model();
		logic [OFFS_W-1:0] offs;
		logic              dec;
		logic [DATA_W-1:0] rd_val;
		int                pin;
		offs   = haddr[OFFS_W-1:0];
		dec    = offs_decoded(offs);
		rd_val = (hsel && !hwrite && dec) ? model_read(REG_IDX_W'(offs >> 2)) : '0;
		if (wr_pend_m) begin // data phase, lands after the read above
			pin = wr_idx_m / REGS_PER_PIN;
			if (wr_idx_m % REGS_PER_PIN == KIND_CTL) ctl_m[pin] = hwdata;
			if (wr_idx_m % REGS_PER_PIN == KIND_OUT) out_m[pin] = hwdata;
		end
		rdata_m   = rd_val;
		err2_m    = err1_m;
		err1_m    = hsel & ~hwrite & ~dec;
		wr_pend_m = hsel & hwrite & dec; // undecoded writes vanish
		wr_idx_m  = REG_IDX_W'(offs >> 2);
		prev_m    = s2_m;
		s2_m      = s1_m;
		s1_m      = gpio_in;
	endtask

	// mid cycle, both the driven inputs and the registered outputs are settled
	always @(negedge hclk) begin
		if (hresetn !== 1'b1) begin
			reset_model();
		end else begin
			compare_outputs();
			advance_model();
		end
	end

endmodule : gpio_checker

`default_nettype wire

//--- tb/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

// free running clock and a reset held low for a fixed number of cycles
module tb_clock_gen #(
	parameter int PERIOD_NS    = 8,
	parameter int RESET_CYCLES = 16
) (
	output logic hclk,
	output logic hresetn
);

	initial begin
		hclk = 1'b0;
		forever #(PERIOD_NS / 2) hclk = ~hclk;
	end

	// release just after an edge, like the rest of the stimulus
	initial begin
		hresetn = 1'b0;
		repeat (RESET_CYCLES) @(posedge hclk);
		#1 hresetn = 1'b1;
	end

endmodule : tb_clock_gen

`default_nettype wire

//--- tb/tb_gpio.sv
`timescale 1ns/1ps
`default_nettype none

module tb_gpio
	import gpio_pkg::*;
();

	localparam int          NUM_SLOTS     = 2000;
	localparam int          CLK_PERIOD_NS = 8;
	localparam int          RESET_CYCLES  = 16;
	localparam int          DRV_DLY_NS    = 1;     // inputs change this long after the edge
	localparam logic [31:0] LFSR_SEED     = 32'd40;

	logic                hclk;
	logic                hresetn;
	logic [31:0]         haddr;
	logic                hsel;
	logic [DATA_W-1:0]   hwdata;
	logic                hwrite;
	logic [DATA_W-1:0]   hrdata;
	logic                hready;
	logic                hresp;
	logic                intc;
	logic [NUM_PINS-1:0] gpio_out;
	logic [NUM_PINS-1:0] gpio_in;
	int                  err_cnt;
	int                  chk_cnt;

	logic [31:0]         lfsr_q;
	logic                wr_pend;  // write address phase sent, data still due
	logic [DATA_W-1:0]   wr_data;

	tb_clock_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) u_clock_gen (
		.hclk    (hclk),
		.hresetn (hresetn)
	);

	gpio_top dut (
		.hclk     (hclk),
		.hresetn  (hresetn),
		.haddr    (haddr),
		.hsel     (hsel),
		.hwdata   (hwdata),
		.hwrite   (hwrite),
		.hrdata   (hrdata),
		.hready   (hready),
		.hresp    (hresp),
		.intc     (intc),
		.gpio_out (gpio_out),
		.gpio_in  (gpio_in)
	);

	gpio_checker u_checker (.*);

	// **********************************************************************
	// random source
	// **********************************************************************
	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q); // one step per bit
			v      = {v[30:0], lfsr_q[0]};
		end
	endtask

	// address phase plus the data phase of any write from the last cycle
	task automatic drive_bus(input logic sel, input logic write, input logic [31:0] addr);
		hsel    = sel;
		hwrite  = write;
		haddr   = addr;
		hwdata  = wr_pend ? wr_data : '0;
		wr_pend = 1'b0;
	endtask

	// **********************************************************************
	// one random slot
	// **********************************************************************
	task automatic run_slot();
		logic [31:0] kind;
		logic [31:0] hi;
		logic [31:0] pin;
		logic [31:0] sub;
		logic [31:0] offs;
		@(posedge hclk);
		#(DRV_DLY_NS);
		while (hready !== 1'b1 || hresp !== 1'b0) begin // error response still running
			drive_bus(1'b0, 1'b0, '0);
			@(posedge hclk);
			#(DRV_DLY_NS);
		end
		rand_bits(2, kind);
		rand_bits(16, hi); // upper address bits are ignored by the dut
		case (kind[1:0])
			2'd1: begin // write to a decoded word, input words included
				rand_bits(2, pin);
				rand_bits(2, sub);
				if (sub > KIND_IN) sub = KIND_CTL;
				offs = (pin * REGS_PER_PIN + sub) * 4;
				drive_bus(1'b1, 1'b1, {hi[15:0], offs[15:0]});
				rand_bits(DATA_W, wr_data);
				wr_pend = 1'b1;
			end
			2'd2: begin
				rand_bits(2, sub);
				if (sub != 3) begin
					rand_bits(REG_IDX_W, offs);
					offs = (offs % NUM_REGS) * 4;
				end else begin
					rand_bits(OFFS_W, offs); // almost always undecoded
				end
				drive_bus(1'b1, 1'b0, {hi[15:0], offs[15:0]});
			end
			2'd3: begin // pad toggle
				rand_bits(2, pin);
				gpio_in[pin[1:0]] = ~gpio_in[pin[1:0]];
				drive_bus(1'b0, 1'b0, '0);
			end
			default: drive_bus(1'b0, 1'b0, '0);
		endcase
	endtask

	initial begin
		#(NUM_SLOTS * 4 * CLK_PERIOD_NS);
		$display("timeout: stimulus did not finish within %0d ns",
			NUM_SLOTS * 4 * CLK_PERIOD_NS);
		$display("sim failed");
		$finish;
	end

	initial begin
		hsel    = 1'b0;
		hwrite  = 1'b0;
		haddr   = '0;
		hwdata  = '0;
		gpio_in = '0;
		lfsr_q  = LFSR_SEED;
		wr_pend = 1'b0;
		wr_data = '0;
		wait (hresetn === 1'b1);
		for (int s = 0; s < NUM_SLOTS; s++) begin
			run_slot();
		end
		// last data phase, then let read data and the pad pipeline settle
		@(posedge hclk);
		#(DRV_DLY_NS);
		drive_bus(1'b0, 1'b0, '0);
		repeat (4) @(posedge hclk);
		#(DRV_DLY_NS);
		$display("checks: %0d  errors: %0d", chk_cnt, err_cnt);
		if (err_cnt == 0 && chk_cnt > 0) begin
			$display("sim passed");
		end else begin
			if (chk_cnt == 0) $display("no output was compared during the run");
			$display("sim failed");
		end
		$finish;
	end

endmodule : tb_gpio

`default_nettype wire

//--- verilog/ahb_slave_port.sv
`timescale 1ns/1ps
`default_nettype none

module ahb_slave_port
	import gpio_pkg::*;
(
	input  logic              hclk,
	input  logic              hresetn,
	input  logic [31:0]       haddr,  // only the low 16 bits are decoded
	input  logic              hsel,   // hsel alone marks an address phase
	input  logic [DATA_W-1:0] hwdata, // data phase of a write
	input  logic              hwrite,
	output logic [DATA_W-1:0] hrdata, // registered read data
	output logic              hready, // low only in the first error cycle
	output logic              hresp,  // high for both error cycles
	reg_bus_if.front          bus
);

	// **********************************************************************
	// declarations
	// **********************************************************************
	logic [OFFS_W-1:0]    offs;        // offset inside the 64k window
	logic                 offs_ok;     // word aligned and inside the map
	logic [REG_IDX_W-1:0] offs_idx;    // register index = offset / 4

	logic                 valid_write; // write address phase this cycle
	logic                 valid_read;  // read address phase this cycle

	logic                 wr_ok_q;     // latched write hit a register
	logic [REG_IDX_W-1:0] wr_idx_q;    // latched write index

	logic                 err_dec_rd;  // undecoded read in address phase
	logic                 err_d1;      // first error cycle
	logic                 err_d2;      // second error cycle

	// **********************************************************************
	// address decode
	// **********************************************************************
	assign offs     = haddr[OFFS_W-1:0];
	assign offs_idx = offs[REG_IDX_W+1:2];

	// anything unaligned or past the last input word is undecoded
	assign offs_ok = (offs[1:0] == 2'b00) &&
		(offs[OFFS_W-1:2] < (OFFS_W-2)'(NUM_REGS));

	assign valid_write = hsel & hwrite;
	assign valid_read  = hsel & ~hwrite;

	// **********************************************************************
	// write path
	// **********************************************************************
	// address phase is held one cycle, data arrives in the next
	always_ff @(posedge hclk or negedge hresetn) begin
		if (!hresetn) begin
			wr_ok_q <= 1'b0;
		end else begin
			wr_ok_q <= valid_write & offs_ok; // undecoded writes just drop out
		end
	end

	// index of the write waiting for its data phase
	always_ff @(posedge hclk or negedge hresetn) begin
		if (!hresetn) begin
			wr_idx_q <= '0;
		end else if (valid_write) begin
			wr_idx_q <= offs_idx;
		end
	end

	assign bus.wr_en  = wr_ok_q;
	assign bus.wr_idx = wr_idx_q;
	assign bus.wdata  = hwdata;   // bank samples it at the strobe edge

	// **********************************************************************
	// read path
	// **********************************************************************
	// mux is driven by the live address, the flop sits on the data side
	assign bus.rd_idx = offs_idx;

	always_ff @(posedge hclk or negedge hresetn) begin
		if (!hresetn) begin
			hrdata <= '0;
		end else if (valid_read && offs_ok) begin
			hrdata <= bus.rdata;
		end else begin
			hrdata <= '0; // idle, write or error cycle
		end
	end

	// **********************************************************************
	// error response
	// **********************************************************************
	// two cycle ahb error for a read of an undecoded offset
	assign err_dec_rd = valid_read & ~offs_ok;

	always_ff @(posedge hclk or negedge hresetn) begin
		if (!hresetn) begin
			err_d1 <= 1'b0;
			err_d2 <= 1'b0;
		end else begin
			err_d1 <= err_dec_rd;
			err_d2 <= err_d1;
		end
	end

	// first cycle waits with hresp up
	assign hready = ~err_d1;
	// second cycle completes with hresp still up
	assign hresp  = err_d1 | err_d2;

endmodule : ahb_slave_port

`default_nettype wire

//--- verilog/gpio_pkg.sv
`default_nettype none

package gpio_pkg;

	// **********************************************************************
	// bus and register widths
	// **********************************************************************
	localparam int DATA_W    = 32; // ahb data bus and register word
	localparam int OFFS_W    = 16; // haddr[15:0] selects the register
	localparam int REG_IDX_W = 4;  // enough for twelve registers

	// **********************************************************************
	// register map
	// **********************************************************************
	// index = pin * REGS_PER_PIN + kind, which is offset / 4
	// so pin i sits at offsets 12*i + 0, 4 and 8
	localparam int NUM_PINS     = 4;
	localparam int REGS_PER_PIN = 3;
	localparam int NUM_REGS     = NUM_PINS * REGS_PER_PIN; // 12 words, offsets 0 to 44

	localparam int KIND_CTL = 0; // interrupt control word
	localparam int KIND_OUT = 1; // pad output word
	localparam int KIND_IN  = 2; // synchronized pad level, read only

	// **********************************************************************
	// control word bits
	// **********************************************************************
	localparam int CTL_IRQ_EN_BIT = 0; // 1 enables the edge interrupt
	localparam int CTL_RISE_BIT   = 1; // 1 for rising edge, 0 for falling

endpackage : gpio_pkg

`default_nettype wire

//--- verilog/gpio_regs.sv
`timescale 1ns/1ps
`default_nettype none

module gpio_regs
	import gpio_pkg::*;
(
	input  logic                hclk,
	input  logic                hresetn,
	reg_bus_if.bank             bus,
	input  logic [NUM_PINS-1:0] pin_level, // synchronized pad levels
	output logic [NUM_PINS-1:0] gpio_out,  // pad drive
	output logic [NUM_PINS-1:0] irq_en,    // per pin interrupt enable
	output logic [NUM_PINS-1:0] irq_rise   // per pin edge polarity
);

	// **********************************************************************
	// storage
	// **********************************************************************
	logic [DATA_W-1:0] ctl_q [NUM_PINS]; // control word per pin
	logic [DATA_W-1:0] out_q [NUM_PINS]; // output word per pin

	// register index of one pin's register
	function automatic logic [REG_IDX_W-1:0] reg_idx(input int pin, input int kind);
		return REG_IDX_W'(pin * REGS_PER_PIN + kind);
	endfunction

	// **********************************************************************
	// register writes
	// **********************************************************************
	// input words are read only, a write there matches nothing
	always_ff @(posedge hclk or negedge hresetn) begin
		if (!hresetn) begin
			for (int p = 0; p < NUM_PINS; p++) begin
				ctl_q[p] <= '0;
				out_q[p] <= '0;
			end
		end else if (bus.wr_en) begin
			for (int p = 0; p < NUM_PINS; p++) begin
				if (bus.wr_idx == reg_idx(p, KIND_CTL)) begin
					ctl_q[p] <= bus.wdata;
				end
				if (bus.wr_idx == reg_idx(p, KIND_OUT)) begin
					out_q[p] <= bus.wdata; // full word kept for readback
				end
			end
		end
	end

	// **********************************************************************
	// read mux
	// **********************************************************************
	// pure combinational so the front end can register it in the same cycle
	always_comb begin
		bus.rdata = '0; // out of range index reads zero
		for (int p = 0; p < NUM_PINS; p++) begin
			if (bus.rd_idx == reg_idx(p, KIND_CTL)) begin
				bus.rdata = ctl_q[p];
			end
			if (bus.rd_idx == reg_idx(p, KIND_OUT)) begin
				bus.rdata = out_q[p];
			end
			if (bus.rd_idx == reg_idx(p, KIND_IN)) begin
				bus.rdata = DATA_W'(pin_level[p]); // zero extended level
			end
		end
	end

	// **********************************************************************
	// pad and interrupt controls
	// **********************************************************************
	always_comb begin
		for (int p = 0; p < NUM_PINS; p++) begin
			gpio_out[p] = out_q[p][0];              // bit 0 drives the pad
			irq_en[p]   = ctl_q[p][CTL_IRQ_EN_BIT];
			irq_rise[p] = ctl_q[p][CTL_RISE_BIT];   // 0 selects falling edge
		end
	end

endmodule : gpio_regs

`default_nettype wire

//--- verilog/gpio_top.sv
`timescale 1ns/1ps
`default_nettype none

module gpio_top
	import gpio_pkg::*;
(
	input  logic                hclk,
	input  logic                hresetn,
	// ahb-lite slave
	input  logic [31:0]         haddr,
	input  logic                hsel,
	input  logic [DATA_W-1:0]   hwdata,
	input  logic                hwrite,
	output logic [DATA_W-1:0]   hrdata,
	output logic                hready,
	output logic                hresp,
	// interrupt controller
	output logic                intc,
	// pads
	output logic [NUM_PINS-1:0] gpio_out,
	input  logic [NUM_PINS-1:0] gpio_in
);

	// **********************************************************************
	// internal connections
	// **********************************************************************
	logic [NUM_PINS-1:0] irq_en;    // control bit 0 per pin
	logic [NUM_PINS-1:0] irq_rise;  // control bit 1 per pin
	logic [NUM_PINS-1:0] pin_level; // synchronized inputs back to the bank

	reg_bus_if bus_if ();           // front end to register bank

	ahb_slave_port u_ahb_slave_port (
		.hclk    (hclk),
		.hresetn (hresetn),
		.haddr   (haddr),
		.hsel    (hsel),
		.hwdata  (hwdata),
		.hwrite  (hwrite),
		.hrdata  (hrdata),
		.hready  (hready),
		.hresp   (hresp),
		.bus     (bus_if.front)
	);

	gpio_regs u_gpio_regs (
		.hclk      (hclk),
		.hresetn   (hresetn),
		.bus       (bus_if.bank),
		.pin_level (pin_level),
		.gpio_out  (gpio_out),
		.irq_en    (irq_en),
		.irq_rise  (irq_rise)
	);

	pin_sync_edge u_pin_sync_edge (
		.hclk      (hclk),
		.hresetn   (hresetn),
		.gpio_in   (gpio_in),
		.irq_en    (irq_en),
		.irq_rise  (irq_rise),
		.pin_level (pin_level),
		.intc      (intc)
	);

endmodule : gpio_top

`default_nettype wire

//--- verilog/pin_sync_edge.sv
`timescale 1ns/1ps
`default_nettype none

module pin_sync_edge
	import gpio_pkg::*;
(
	input  logic                hclk,
	input  logic                hresetn,
	input  logic [NUM_PINS-1:0] gpio_in,   // asynchronous pad inputs
	input  logic [NUM_PINS-1:0] irq_en,
	input  logic [NUM_PINS-1:0] irq_rise,
	output logic [NUM_PINS-1:0] pin_level, // level seen by the input registers
	output logic                intc       // active high to the interrupt controller
);

	// **********************************************************************
	// declarations
	// **********************************************************************
	logic [NUM_PINS-1:0] sync1_q; // first synchronizer stage
	logic [NUM_PINS-1:0] sync2_q; // second stage, safe to use
	logic [NUM_PINS-1:0] prev_q;  // level one cycle behind sync2_q

	logic [NUM_PINS-1:0] rise;    // 0 to 1 between prev_q and sync2_q
	logic [NUM_PINS-1:0] fall;    // 1 to 0 between prev_q and sync2_q
	logic [NUM_PINS-1:0] irq_pin; // per pin interrupt after gating

	// **********************************************************************
	// synchronizer and previous level
	// **********************************************************************
	// pad sampled at S shows on pin_level from S+2
	always_ff @(posedge hclk or negedge hresetn) begin
		if (!hresetn) begin
			sync1_q <= '0;
			sync2_q <= '0;
			prev_q  <= '0;
		end else begin
			sync1_q <= gpio_in;
			sync2_q <= sync1_q;
			prev_q  <= sync2_q;
		end
	end

	assign pin_level = prev_q;

	// **********************************************************************
	// edge detect and interrupt
	// **********************************************************************
	// every pin compares its own two samples
	assign rise = sync2_q & ~prev_q;
	assign fall = ~sync2_q & prev_q;

	// an edge lasts one cycle, so the interrupt is a single cycle pulse
	assign irq_pin = irq_en & ((irq_rise & rise) | (~irq_rise & fall));

	assign intc = |irq_pin; // all pins share one line

endmodule : pin_sync_edge

`default_nettype wire

//--- verilog/reg_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

// decoded register accesses between the ahb front end and the register bank
// wr_en is a single cycle strobe and the bank writes on that edge
interface reg_bus_if
	import gpio_pkg::*;
();

	logic                 wr_en;  // write strobe in the data phase
	logic [REG_IDX_W-1:0] wr_idx; // latched write index
	logic [DATA_W-1:0]    wdata;  // hwdata passed straight through
	logic [REG_IDX_W-1:0] rd_idx; // read index from the live address
	logic [DATA_W-1:0]    rdata;  // selected word, no latency

	// bus side
	modport front (
		output wr_en, wr_idx, wdata, rd_idx,
		input  rdata
	);

	// register side
	modport bank (
		input  wr_en, wr_idx, wdata, rd_idx,
		output rdata
	);

endinterface : reg_bus_if

`default_nettype wire
